/* build.f */
source/u712Pkg.sv
source/cpuAddrDecode.sv
source/agnusPhaseSync.sv
source/regCycleSm.sv
source/u712Bus.sv
tb/u712BusTb.sv

/* Bender.yml */
package:
  name: u712_bus

sources:
  - files:
      - source/u712Pkg.sv
      - source/cpuAddrDecode.sv
      - source/agnusPhaseSync.sv
      - source/regCycleSm.sv
      - source/u712Bus.sv
  - target: simulation
    files:
      - tb/u712BusTb.sv

/* tb/u712BusTb.sv */
`timescale 1ns/1ns
`default_nettype none

module u712BusTb;

    localparam int CLK_HALF_NS    = 2;   // 4 ns CLK80 period
    localparam int PHASE_HALF     = 40;  // CLK80 cycles per C1/C3 half period
    localparam int PHASE_PERIOD   = 2 * PHASE_HALF;
    localparam int CYCLE_BUDGET   = 320; // Clocks per register cycle
    localparam int HOLD_CLOCKS    = 200; // dbrN low time in the hold test
    localparam int TIMEOUT_CYCLES = 8 * CYCLE_BUDGET + 1440; // 8 cycles plus margin
    localparam u712Pkg::chipStrobes_t ALL_HIGH = 4'b1111;

    logic                  CLK80    = 1'b0;
    logic                  c1       = 1'b1; // Quarter 0 is C1 high, C3 low
    logic                  c3       = 1'b0;
    int                    phaseCnt = 0;
    int                    cycleCount = 0;
    logic                  RESETn;
    logic                  tsN;
    logic [31:0]           addr;
    logic                  rnW;
    logic                  siz0;
    logic                  dbrN;
    u712Pkg::chipStrobes_t strobes;
    logic                  regTack;
    int                    valueErrors;
    int                    otherErrors;
    logic [31:0]           rngState;

    u712Bus u712Bus_inst (
        .CLK80(CLK80), .RESETn(RESETn), .c1(c1), .c3(c3), .tsN(tsN), .addr(addr),
        .rnW(rnW), .siz0(siz0), .dbrN(dbrN), .strobes(strobes), .regTack(regTack)
    );

    always #(CLK_HALF_NS) CLK80 = ~CLK80;

    // Quadrature phase clocks, C3 lags C1 by a quarter period
    always @(posedge CLK80) begin
        phaseCnt <= (phaseCnt == PHASE_PERIOD - 1) ? 0 : phaseCnt + 1;
        c1 <= (phaseCnt < PHASE_HALF);
        c3 <= (phaseCnt >= PHASE_HALF / 2) && (phaseCnt < PHASE_HALF + PHASE_HALF / 2);
    end

    always @(posedge CLK80) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a test never finished", cycleCount);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic logic [31:0] insideAddr(input logic a0);
        return u712Pkg::REG_BASE | (nextRandom() & 32'h0000_0FFE) | {31'd0, a0};
    endfunction

    function automatic logic [31:0] outsideAddr();
        logic [31:0] x;
        x = nextRandom();
        if ((x & u712Pkg::REG_MASK) == u712Pkg::REG_BASE) x[31] = ~x[31]; // Force a miss
        return x;
    endfunction

    task automatic checkStrobes(input string testName, input u712Pkg::chipStrobes_t expected,
                                input u712Pkg::chipStrobes_t actual);
        if (actual !== expected) begin
            valueErrors++;
            $display("FAIL %s: expected %b actual %b", testName, expected, actual);
        end
    endtask

    task automatic checkBit(input string testName, input logic expected, input logic actual);
        if (actual !== expected) begin
            valueErrors++;
            $display("FAIL %s: expected %b actual %b", testName, expected, actual);
        end
    endtask

    task automatic reportProblem(input string msg);
        otherErrors++;
        $display("ERROR: %s", msg);
    endtask

    // One-clock tsN pulse, address scrambled afterwards to prove the latch
    task automatic startTransfer(input logic [31:0] a, input logic rd, input logic byteSz);
        @(posedge CLK80);
        tsN  <= 1'b0;
        addr <= a;
        rnW  <= rd;
        siz0 <= byteSz;
        @(posedge CLK80);
        tsN  <= 1'b1;
        addr <= outsideAddr();
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic resetTest();
        for (int i = 0; i < 10; i++) begin
            @(posedge CLK80);
            if (i >= 2) begin // Outputs unknown before the first reset edge
                checkStrobes("reset strobes", ALL_HIGH, strobes);
                checkBit("reset regTack", 1'b0, regTack);
            end
        end
        RESETn <= 1'b1;
        repeat (4) begin
            @(posedge CLK80);
            checkStrobes("after reset strobes", ALL_HIGH, strobes);
            checkBit("after reset regTack", 1'b0, regTack);
        end
    endtask

    // Full register cycle with lane and ordering checks
    task automatic runCycle(input string testName, input logic [31:0] a, input logic rd,
                            input logic byteSz, input logic udsExp, input logic ldsExp,
                            input int holdClocks);
        u712Pkg::chipStrobes_t dsExp;
        u712Pkg::chipStrobes_t s2Exp;
        int   waitCnt;
        int   holdCnt;
        int   tackCount;
        logic seenS4;      // Own view of C3 rising with C1 high
        logic seenBothLow;
        logic c3Prev;
        dsExp.asN    = 1'b0;
        dsExp.udsN   = !udsExp;
        dsExp.ldsN   = !ldsExp;
        dsExp.regEnN = 1'b0;
        s2Exp        = dsExp;
        if (!rd) begin
            s2Exp.udsN = 1'b1; // Write strobes held back until s4
            s2Exp.ldsN = 1'b1;
        end
        waitCnt     = 0;
        holdCnt     = 0;
        tackCount   = 0;
        seenS4      = 1'b0;
        seenBothLow = 1'b0;
        @(posedge CLK80);
        dbrN <= (holdClocks == 0);
        startTransfer(a, rd, byteSz);
        while (strobes.asN && waitCnt < CYCLE_BUDGET) begin
            @(posedge CLK80);
            waitCnt++;
        end
        if (strobes.asN) begin
            reportProblem({testName, ": asN never fell"});
            return;
        end
        checkStrobes({testName, " at s2"}, s2Exp, strobes);
        c3Prev  = c3;
        waitCnt = 0;
        while (!strobes.asN && waitCnt < CYCLE_BUDGET + holdClocks) begin
            if (c1 && c3 && !c3Prev) seenS4 = 1'b1;
            if (seenS4 && !c1 && !c3) seenBothLow = 1'b1;
            c3Prev = c3;
            if (!strobes.udsN || !strobes.ldsN) begin
                if (!rd && !seenS4) reportProblem({testName, ": data strobe fell before s4"});
                checkStrobes({testName, " data strobes"}, dsExp, strobes);
            end
            if (regTack) begin
                tackCount++;
                checkStrobes({testName, " at regTack"}, dsExp, strobes);
                if (!dbrN) reportProblem({testName, ": regTack while dbrN low"});
                if (!rd && !seenBothLow) reportProblem({testName, ": regTack before C1/C3 low"});
            end
            if (holdClocks > 0 && holdCnt == holdClocks) dbrN <= 1'b1; // Chipset lets go
            holdCnt++;
            @(posedge CLK80);
            waitCnt++;
        end
        if (holdCnt <= holdClocks) reportProblem({testName, ": cycle ended while dbrN low"});
        if (!strobes.asN) reportProblem({testName, ": asN never rose"});
        if (tackCount != 1) begin
            reportProblem($sformatf("%s: regTack high for %0d cycles", testName, tackCount));
        end
        checkStrobes({testName, " end strobes"}, ALL_HIGH, strobes);
        checkBit({testName, " end regTack"}, 1'b0, regTack);
    endtask

    // Long enough that a false hit would surely reach s2 inside the window
    task automatic outsideWindowTest();
        startTransfer(outsideAddr(), 1'b1, 1'b0);
        repeat (2 * PHASE_PERIOD) begin
            @(posedge CLK80);
            checkStrobes("outside strobes", ALL_HIGH, strobes);
            checkBit("outside regTack", 1'b0, regTack);
        end
    endtask

    initial begin
        RESETn      = 1'b0;
        tsN         = 1'b1;
        addr        = 32'd0;
        rnW         = 1'b1;
        siz0        = 1'b0;
        dbrN        = 1'b1;
        valueErrors = 0;
        otherErrors = 0;
        rngState    = 32'd98;
        resetTest();
        runCycle("wordRead", insideAddr(1'b0), 1'b1, 1'b0, 1'b1, 1'b1, 0);
        runCycle("byteWriteA0", insideAddr(1'b0), 1'b0, 1'b1, 1'b1, 1'b0, 0);
        runCycle("byteWriteA1", insideAddr(1'b1), 1'b0, 1'b1, 1'b0, 1'b1, 0);
        runCycle("chipsetHold", insideAddr(1'b0), 1'b1, 1'b0, 1'b1, 1'b1, HOLD_CLOCKS);
        outsideWindowTest();
        $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/u712Bus.sv */
`timescale 1ns/1ns
`default_nettype none

module u712Bus (
    input  wire logic        CLK80,
    input  wire logic        RESETn,
    input  wire logic        c1,
    input  wire logic        c3,
    input  wire logic        tsN,
    input  wire logic [31:0] addr,
    input  wire logic        rnW,
    input  wire logic        siz0,
    input  wire logic        dbrN,
    output u712Pkg::chipStrobes_t strobes,
    output logic             regTack
);

    wire u712Pkg::cpuReq_t   cpuReq;   // Latched request
    wire u712Pkg::busPhase_t busPhase; // Recovered 68000 states

    ////////////////////
    // CPU side decode
    ////////////////////

    cpuAddrDecode cpuAddrDecode_inst (
        .CLK80  (CLK80),
        .RESETn (RESETn),
        .tsN    (tsN),
        .addr   (addr),
        .rnW    (rnW),
        .siz0   (siz0),
        .req    (cpuReq)
    );

    // Phase clocks and bus request from the chipset
    agnusPhaseSync agnusPhaseSync_inst (
        .CLK80  (CLK80),
        .RESETn (RESETn),
        .c1     (c1),
        .c3     (c3),
        .dbrN   (dbrN),
        .phase  (busPhase)
    );

    regCycleSm regCycleSm_inst (
        .CLK80   (CLK80),
        .RESETn  (RESETn),
        .tsN     (tsN),
        .req     (cpuReq),
        .phase   (busPhase),
        .strobes (strobes),
        .regTack (regTack)
    );

endmodule

`default_nettype wire

/* source/regCycleSm.sv */
`timescale 1ns/1ns
`default_nettype none

module regCycleSm (
    input  wire logic             CLK80,
    input  wire logic             RESETn,
    input  wire logic             tsN,
    input  wire u712Pkg::cpuReq_t req,
    input  wire u712Pkg::busPhase_t phase,
    output u712Pkg::chipStrobes_t strobes,
    output logic                  regTack
);

    // Each state waits for the phase strobe of the same name
    typedef enum logic [2:0] {
        stIdle = 3'd0,
        stS2   = 3'd1,
        stS4   = 3'd2,
        stWait = 3'd3,
        stS5   = 3'd4,
        stS6   = 3'd5,
        stS7   = 3'd6
    } cycleState_t;

    cycleState_t state;
    logic        tsSeen; // tsN low seen last edge
    logic        regEnN;
    logic        dsEn;   // Gates both data strobes
    logic        udsSel; // Upper lane wanted
    logic        ldsSel; // Lower lane wanted

    ////////////////////
    // Cycle FSM
    ////////////////////

    always_ff @(negedge CLK80) begin
        if (!RESETn) begin
            state   <= stIdle;
            tsSeen  <= 1'b0;
            regEnN  <= 1'b1;
            dsEn    <= 1'b0;
            regTack <= 1'b0;
        end else begin
            regTack <= 1'b0; // Pulse only

            case (state)
                stIdle: begin
                    tsSeen <= !tsN;
                    // Latched hit is valid one edge after tsN
                    if (tsSeen && req.hit) begin
                        tsSeen <= 1'b0;
                        state  <= stS2;
                    end
                end

                stS2: begin
                    if (phase.s2) begin
                        regEnN <= 1'b0; // Address strobe and enable together
                        // Word or read: both lanes; byte: a0 picks the lane
                        udsSel <= req.rnW || !req.a0 || !req.siz0;
                        ldsSel <= req.rnW || req.a0 || !req.siz0;
                        dsEn   <= req.rnW; // Reads drive strobes right away
                        state  <= stS4;
                    end
                end

                stS4: begin
                    if (phase.s4) begin
                        dsEn  <= 1'b1; // Write data now stable
                        state <= stWait;
                    end
                end

                stWait: begin
                    // Wait states while chipset owns the bus
                    if (phase.dbrIdle && phase.s4Idle) begin
                        state <= stS5;
                    end
                end

                stS5: begin
                    if (phase.s5) begin
                        regTack <= req.rnW; // Read data latched early
                        state   <= stS6;
                    end
                end

                stS6: begin
                    if (phase.s6) begin
                        regTack <= !req.rnW; // Write ends here
                        state   <= stS7;
                    end
                end

                stS7: begin
                    if (phase.s7) begin
                        regEnN <= 1'b1; // All strobes released
                        dsEn   <= 1'b0;
                        state  <= stIdle;
                    end
                end

                default: state <= stIdle;
            endcase
        end
    end

    ////////////////////
    // Strobe outputs
    ////////////////////

    always_comb begin
        strobes.asN    = regEnN; // AS follows the register enable
        strobes.regEnN = regEnN;
        strobes.udsN   = !(udsSel && dsEn);
        strobes.ldsN   = !(ldsSel && dsEn);
    end

    // Acknowledge is a single clock pulse toward the CPU
    tackOneCycle : assert property (
        @(negedge CLK80) disable iff (!RESETn)
        regTack |=> !regTack
    ) else $error("regCycleSm: regTack longer than one cycle");

    // Data strobes only inside an address strobe frame
    dsInsideAs : assert property (
        @(negedge CLK80) disable iff (!RESETn)
        (!strobes.udsN || !strobes.ldsN) |-> !strobes.asN
    ) else $error("regCycleSm: data strobe without asN");

endmodule

`default_nettype wire

/* source/agnusPhaseSync.sv */
`timescale 1ns/1ns
`default_nettype none

module agnusPhaseSync (
    input  wire logic          CLK80,
    input  wire logic          RESETn,
    input  wire logic          c1,
    input  wire logic          c3,
    input  wire logic          dbrN,
    output u712Pkg::busPhase_t phase
);

    logic [2:0] c1Sync;   // [0] newest sample
    logic [2:0] c3Sync;
    logic [1:0] dbrSync;
    logic       bothLow;  // C1 and C3 low past the first stage
    logic       bothLowQ;
    logic       s2Q;
    logic       s4Q;
    logic       s4IdleQ;
    logic       s5Q;
    logic       s6Q;
    logic       s7Q;

    assign bothLow = (c1Sync[2:1] == 2'b00) && (c3Sync[2:1] == 2'b00);

    ////////////////////
    // Sync and decode
    ////////////////////

    always_ff @(negedge CLK80) begin
        if (!RESETn) begin
            c1Sync   <= 3'b111; // Idle high
            c3Sync   <= 3'b111;
            dbrSync  <= 2'b11;  // Chipset idle
            bothLowQ <= 1'b0;
            s2Q      <= 1'b0;
            s4Q      <= 1'b0;
            s4IdleQ  <= 1'b0;
            s5Q      <= 1'b0;
            s6Q      <= 1'b0;
            s7Q      <= 1'b0;
        end else begin
            c1Sync   <= {c1Sync[1:0], c1};
            c3Sync   <= {c3Sync[1:0], c3};
            dbrSync  <= {dbrSync[0], dbrN};
            bothLowQ <= bothLow;
            // Edges judged on stages 2 and 1, stage 0 only catches the pin
            s2Q <= (c1Sync[2:1] == 2'b00) && (c3Sync[2:1] == 2'b10); // C3 fall, C1 low
            s4Q <= (c1Sync[2:1] == 2'b11) && (c3Sync[2:1] == 2'b01); // C3 rise, C1 high
            s5Q <= (c1Sync[2:1] == 2'b10) && (c3Sync[2:1] == 2'b11); // C1 fall, C3 high
            s6Q <= bothLow && !bothLowQ;                             // First cycle both low
            s7Q <= (c1Sync[2:1] == 2'b01) && (c3Sync[2:1] == 2'b00); // C1 rise, C3 low
            s4IdleQ <= (c1Sync == 3'b111) && (c3Sync == 3'b111);     // All stages high
        end
    end

    always_comb begin
        phase.s2      = s2Q;
        phase.s4      = s4Q;
        phase.s4Idle  = s4IdleQ;
        phase.s5      = s5Q;
        phase.s6      = s6Q;
        phase.s7      = s7Q;
        phase.dbrIdle = (dbrSync == 2'b11); // Two high samples
    end

    // Quadrature phase clocks never give two bus states in one cycle
    onePhaseStrobe : assert property (
        @(negedge CLK80) disable iff (!RESETn)
        $onehot0({phase.s2, phase.s4, phase.s5, phase.s6, phase.s7})
    ) else $error("agnusPhaseSync: overlapping bus state strobes");

endmodule

`default_nettype wire

/* source/cpuAddrDecode.sv */
`timescale 1ns/1ns
`default_nettype none

module cpuAddrDecode (
    input  wire logic        CLK80,
    input  wire logic        RESETn,
    input  wire logic        tsN,
    input  wire logic [31:0] addr,
    input  wire logic        rnW,
    input  wire logic        siz0,
    output u712Pkg::cpuReq_t req
);

    logic winHit;

    ////////////////////
    // Window compare
    ////////////////////

    // Only the masked bits matter, low 12 bits select the register
    assign winHit = (addr & u712Pkg::REG_MASK)
                 == (u712Pkg::REG_BASE & u712Pkg::REG_MASK);

    ////////////////////
    // Request latch
    ////////////////////

    // Captured once per transfer start, held until next tsN
    always_ff @(negedge CLK80) begin
        if (!RESETn) begin
            req.hit <= 1'b0; // No stale hit after reset
        end else if (!tsN) begin
            req.hit  <= winHit;
            req.rnW  <= rnW;
            req.siz0 <= siz0;
            req.a0   <= addr[0]; // Lane select for the data strobes
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // A floating address at transfer start would corrupt the latched hit
    addrKnownAtTs : assert property (
        @(negedge CLK80) disable iff (!RESETn)
        !tsN |-> !$isunknown(addr)
    ) else $error("cpuAddrDecode: address unknown while tsN low");

endmodule

`default_nettype wire

/* source/u712Pkg.sv */
`default_nettype none

package u712Pkg;

    ////////////////////
    // Register window
    ////////////////////

    localparam logic [31:0] REG_BASE = 32'h00DF_F000; // Custom chip register space
    localparam logic [31:0] REG_MASK = 32'hFFFF_F000; // Upper 20 address bits

    ////////////////////
    // Shared bundles
    ////////////////////

    // Request fields frozen at transfer start
    typedef struct packed {
        logic hit;  // Address inside register window
        logic rnW;  // 1 = read
        logic siz0; // 1 = byte transfer
        logic a0;   // Byte lane select
    } cpuReq_t;

    // 68000 bus state strobes recovered from C1/C3
    typedef struct packed {
        logic s2;      // Pulse
        logic s4;      // Pulse
        logic s4Idle;  // Level, C1 and C3 steady high
        logic s5;      // Pulse
        logic s6;      // Pulse
        logic s7;      // Pulse
        logic dbrIdle; // Level, chipset not requesting
    } busPhase_t;

    // Active low chipset side
    typedef struct packed {
        logic asN;
        logic udsN;
        logic ldsN;
        logic regEnN;
    } chipStrobes_t;

endpackage

`default_nettype wire
